// ==== uart_ldr.f ====
logic/uart_ldr_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/ram_cmd.sv
logic/mem_arb.sv
logic/ram.sv
logic/uart_ldr_top.sv
tests/uart_ldr_sva.sv
tests/uart_ldr_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := uart_ldr_tb
FILELIST  := uart_ldr.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall --timing
PASS_MSG  := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The run fails unless the pass message appears on a line of its own
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/uart_ldr_tb.sv ====
`timescale 1ns/1ps

module uart_ldr_tb;

    import uart_ldr_pkg::*;

    localparam int N_WR    = 4;   // Word writes, then reads, in the write/read test
    localparam int N_MIXED = 3;
    localparam int N_BUSY  = 2;
    localparam int N_B2B   = 4;

    // A UART write is 6 frames out and 1 back, a read 2 out and 4 back
    localparam int FRAMES         = (N_WR + N_MIXED + N_BUSY) * 13 + 12 + N_B2B * 6;
    localparam int TIMEOUT_CYCLES = FRAMES * BAUD_DIV * 10 * 5 / 4;
    localparam int BYTE_WAIT      = 20 * BAUD_DIV * 10;
    localparam int GNT_WAIT       = 16;

    logic     clk;
    logic     rst;
    logic     uart_rx;
    logic     uart_tx;
    mem_req_t core_req;
    mem_rsp_t core_rsp;
    logic     cpu_run;

    word_t       model [MEM_WORDS];
    byte_t       rx_q [$];
    logic [31:0] lfsr;
    string       cur_test;
    int          total_checks;
    int          total_errs;
    int          checks_at_start;
    int          errs_at_start;
    int          tests_run;
    int          cycle_cnt;
    int          core_ops;
    logic        uart_busy;
    addr_t       addrs [8];
    word_t       datas [8];

    uart_ldr_top uut (
        .clk_i(clk),
        .rst_i(rst),
        .uart_rx_i(uart_rx),
        .uart_tx_o(uart_tx),
        .core_req_i(core_req),
        .core_rsp_o(core_rsp),
        .cpu_run_o(cpu_run)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Random numbers and result bookkeeping
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        end
        return r;
    endfunction

    function automatic addr_t low_addr();   // Host side of the address map
        return addr_t'(rand_bits(7));
    endfunction

    function automatic addr_t high_addr();  // Core side under contention
        return addr_t'(rand_bits(7)) | 8'h80;
    endfunction

    task automatic compare_value(input word_t exp, input word_t act);
        total_checks++;
        assert (act === exp) else begin
            $display("FAIL %s expected %h actual %h", cur_test, exp, act);
            total_errs++;
        end
    endtask

    task automatic require(input logic cond, input string what);
        total_checks++;
        assert (cond) else begin
            $display("%s: %s", cur_test, what);
            total_errs++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test        = name;
        checks_at_start = total_checks;
        errs_at_start   = total_errs;
    endtask

    task automatic close_test();
        tests_run++;
        $display("test %s: %0d checks, %0d errors", cur_test,
                 total_checks - checks_at_start, total_errs - errs_at_start);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Serial line
    task automatic send_byte(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            uart_rx <= frame[i];
            repeat (BAUD_DIV - 1) @(posedge clk);
        end
        repeat (BAUD_DIV) @(posedge clk);   // Idle bit between frames
    endtask

    // Decodes uart_tx_o at mid-bit, sampled on the falling edge
    initial begin
        byte_t b;
        wait (rst === 1'b0);
        forever begin
            @(negedge clk);
            if (uart_tx === 1'b0) begin
                repeat (BAUD_DIV / 2 - 1) @(negedge clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (BAUD_DIV) @(negedge clk);
                    b[i] = uart_tx;
                end
                repeat (BAUD_DIV) @(negedge clk);
                require(uart_tx === 1'b1, "stop bit missing on uart_tx_o");
                rx_q.push_back(b);
            end
        end
    end

    task automatic await_byte(input byte_t exp);
        int waited;
        waited = 0;
        while (rx_q.size() == 0 && waited < BYTE_WAIT) begin
            @(negedge clk);
            waited++;
        end
        require(rx_q.size() != 0, "no reply byte arrived on uart_tx_o");
        if (rx_q.size() != 0) compare_value(word_t'(exp), word_t'(rx_q.pop_front()));
    endtask

    task automatic await_word(input word_t w);
        for (int i = 0; i < 4; i++) begin
            await_byte(w[i*8 +: 8]);   // LSB first
        end
    endtask

    task automatic write_by_uart(input addr_t a, input word_t d);
        send_byte(CMD_WRITE);
        send_byte(a);
        for (int i = 0; i < 4; i++) begin
            send_byte(d[i*8 +: 8]);
        end
        await_byte(RSP_ACK);
        model[a] = d;
    endtask

    task automatic read_by_uart(input addr_t a);
        send_byte(CMD_READ);
        send_byte(a);
        await_word(model[a]);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Core data port
    task automatic core_access(input logic wr, input addr_t a, input word_t d, input be_t be);
        mem_req_t req;
        int       waited;
        req.valid = 1'b1;
        req.write = wr;
        req.addr  = a;
        req.wdata = d;
        req.be    = be;
        waited    = 0;
        @(posedge clk);
        core_req <= req;
        @(negedge clk);
        while (!core_rsp.gnt && waited < GNT_WAIT) begin
            @(negedge clk);
            waited++;
        end
        require(core_rsp.gnt && waited < 2, "core request not granted within two cycles");
        if (wr) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) model[a][i*8 +: 8] = d[i*8 +: 8];
            end
        end
        @(posedge clk);
        core_req.valid <= 1'b0;
        if (!wr) begin
            @(negedge clk);
            require(core_rsp.rvalid, "no read valid one cycle after the core read grant");
            compare_value(model[a], core_rsp.rdata);
        end
    endtask

    task automatic preload_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            core_access(1'b1, addr_t'(i), rand_bits(32), 4'hf);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    initial begin
        be_t  rand_be;
        lfsr         = 32'heefd_4438;
        total_checks = 0;
        total_errs   = 0;
        tests_run    = 0;
        cycle_cnt    = 0;
        core_ops     = 0;
        uart_busy    = 1'b0;
        rst          = 1'b1;
        uart_rx      = 1'b1;
        core_req     = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        start_test("reset_state");
        compare_value(32'd1, word_t'(uart_tx));
        compare_value(32'd0, word_t'(cpu_run));
        compare_value(32'd0, word_t'({core_rsp.gnt, core_rsp.rvalid}));
        close_test();

        preload_memory();

        start_test("write_read");
        for (int i = 0; i < N_WR; i++) begin
            addrs[i] = low_addr();
            datas[i] = rand_bits(32);
            write_by_uart(addrs[i], datas[i]);
        end
        for (int i = 0; i < N_WR; i++) begin
            read_by_uart(addrs[i]);
        end
        close_test();

        start_test("shared_access");
        for (int i = 0; i < N_MIXED; i++) begin
            addrs[i] = high_addr();
            datas[i] = rand_bits(32);
            rand_be  = be_t'(rand_bits(4));
            core_access(1'b1, addrs[i], datas[i], rand_be);
            read_by_uart(addrs[i]);
        end
        for (int i = 0; i < N_MIXED; i++) begin
            addrs[i] = low_addr();
            datas[i] = rand_bits(32);
            write_by_uart(addrs[i], datas[i]);
            core_access(1'b0, addrs[i], '0, '0);
        end
        close_test();

        start_test("run_control");
        send_byte(CMD_GO);
        await_byte(RSP_ACK);
        compare_value(32'd1, word_t'(cpu_run));
        send_byte(8'h3c);   // Not a command opcode
        await_byte(RSP_NAK);
        compare_value(32'd1, word_t'(cpu_run));
        send_byte(CMD_HALT);
        await_byte(RSP_ACK);
        compare_value(32'd0, word_t'(cpu_run));
        read_by_uart(addrs[0]);
        close_test();

        start_test("core_contention");
        for (int i = 0; i < N_BUSY; i++) begin
            addrs[i] = low_addr();
            datas[i] = rand_bits(32);
        end
        uart_busy = 1'b1;
        fork
            begin
                for (int i = 0; i < N_BUSY; i++) begin
                    write_by_uart(addrs[i], datas[i]);
                end
                for (int i = 0; i < N_BUSY; i++) begin
                    read_by_uart(addrs[i]);
                end
                uart_busy = 1'b0;
            end
            begin : core_traffic
                addr_t a;
                word_t d;
                be_t   b;
                logic  w;
                while (uart_busy) begin
                    w = rand_bits(1) != 0;
                    a = high_addr();
                    d = rand_bits(32);
                    b = be_t'(rand_bits(4));
                    core_access(w, a, d, b);
                    core_ops++;
                end
            end
        join
        require(core_ops > 0, "core port issued no requests");
        close_test();

        start_test("b2b_reads");
        for (int i = 0; i < N_B2B; i++) begin
            addrs[i] = low_addr();
        end
        for (int i = 0; i < N_B2B; i++) begin
            send_byte(CMD_READ);
            send_byte(addrs[i]);
        end
        for (int i = 0; i < N_B2B; i++) begin
            await_word(model[addrs[i]]);
        end
        repeat (BAUD_DIV * 12) @(negedge clk);   // Long enough for a stray frame to land
        require(rx_q.size() == 0, "extra reply bytes on uart_tx_o");
        close_test();

        $display("%0d tests, %0d checks, %0d errors", tests_run, total_checks, total_errs);
        if (total_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== tests/uart_ldr_sva.sv ====
`timescale 1ns/1ps

module uart_ldr_sva (
    input logic                  clk_i,
    input logic                  rst_i,
    input logic                  cmd_gnt_i,
    input logic                  cmd_rd_i,
    input logic                  cmd_rvalid_i,
    input logic                  core_gnt_i,
    input logic                  core_rd_i,
    input logic                  core_rvalid_i,
    input uart_ldr_pkg::tx_cnt_t tx_credits_i
);

    import uart_ldr_pkg::*;

    one_grant: assert property (@(posedge clk_i) disable iff (rst_i)
        !(cmd_gnt_i && core_gnt_i))
        else $error("both masters granted in the same cycle");

    // Read data comes back exactly one cycle after a read grant
    cmd_read_latency: assert property (@(posedge clk_i) disable iff (rst_i)
        cmd_rvalid_i == $past(cmd_gnt_i && cmd_rd_i))
        else $error("command engine read valid not one cycle after its read grant");

    core_read_latency: assert property (@(posedge clk_i) disable iff (rst_i)
        core_rvalid_i == $past(core_gnt_i && core_rd_i))
        else $error("core read valid not one cycle after its read grant");

    credit_range: assert property (@(posedge clk_i) disable iff (rst_i)
        tx_credits_i <= tx_cnt_t'(TX_CREDITS))
        else $error("tx credit counter outside zero to TX_CREDITS");

endmodule

bind mem_arb uart_ldr_sva arb_sva (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .cmd_gnt_i(cmd_rsp_o.gnt),
    .cmd_rd_i(!cmd_req_i.write),
    .cmd_rvalid_i(cmd_rsp_o.rvalid),
    .core_gnt_i(core_rsp_o.gnt),
    .core_rd_i(!core_req_i.write),
    .core_rvalid_i(core_rsp_o.rvalid),
    .tx_credits_i('0)
);

bind ram_cmd uart_ldr_sva cmd_sva (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .cmd_gnt_i(1'b0),
    .cmd_rd_i(1'b0),
    .cmd_rvalid_i(1'b0),
    .core_gnt_i(1'b0),
    .core_rd_i(1'b0),
    .core_rvalid_i(1'b0),
    .tx_credits_i(tx_credits)
);

// ==== logic/uart_ldr_top.sv ====
`timescale 1ns/1ps

module uart_ldr_top (
    input  logic                   clk_i,
    input  logic                   rst_i,

    input  logic                   uart_rx_i,
    output logic                   uart_tx_o,

    input  uart_ldr_pkg::mem_req_t core_req_i,
    output uart_ldr_pkg::mem_rsp_t core_rsp_o,

    output logic                   cpu_run_o
);

    import uart_ldr_pkg::*;

    byte_t    rx_byte;
    logic     rx_push;
    logic     rx_credit;

    byte_t    tx_byte;
    logic     tx_push;
    logic     tx_credit;

    mem_req_t cmd_req;
    mem_rsp_t cmd_rsp;
    mem_req_t ram_req;
    word_t    ram_rdata;

    uart_rx uart_rx (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .uart_rx_i(uart_rx_i),
        .rx_credit_i(rx_credit),
        .rx_byte_o(rx_byte),
        .rx_push_o(rx_push)
    );

    uart_tx uart_tx (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .tx_byte_i(tx_byte),
        .tx_push_i(tx_push),
        .uart_tx_o(uart_tx_o),
        .tx_credit_o(tx_credit)
    );

    ram_cmd ram_cmd (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .rx_byte_i(rx_byte),
        .rx_push_i(rx_push),
        .rx_credit_o(rx_credit),
        .tx_byte_o(tx_byte),
        .tx_push_o(tx_push),
        .tx_credit_i(tx_credit),
        .mem_req_o(cmd_req),
        .mem_rsp_i(cmd_rsp),
        .cpu_run_o(cpu_run_o)
    );

    mem_arb mem_arb (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .cmd_req_i(cmd_req),
        .core_req_i(core_req_i),
        .cmd_rsp_o(cmd_rsp),
        .core_rsp_o(core_rsp_o),
        .ram_req_o(ram_req),
        .ram_rdata_i(ram_rdata)
    );

    ram ram (
        .clk_i(clk_i),
        .ram_req_i(ram_req),
        .ram_rdata_o(ram_rdata)
    );

endmodule

// ==== logic/ram.sv ====
`timescale 1ns/1ps

module ram (
    input  logic                   clk_i,
    input  uart_ldr_pkg::mem_req_t ram_req_i,
    output uart_ldr_pkg::word_t    ram_rdata_o
);

    import uart_ldr_pkg::*;

    word_t mem [MEM_WORDS];

    always_ff @(posedge clk_i) begin
        if (ram_req_i.valid) begin
            if (ram_req_i.write) begin
                for (int i = 0; i < $bits(be_t); i++) begin
                    if (ram_req_i.be[i]) begin
                        mem[ram_req_i.addr][i*8 +: 8] <= ram_req_i.wdata[i*8 +: 8];
                    end
                end
            end else begin
                ram_rdata_o <= mem[ram_req_i.addr];   // Data is ready one cycle later
            end
        end
    end

endmodule

// ==== logic/mem_arb.sv ====
`timescale 1ns/1ps

module mem_arb (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  uart_ldr_pkg::mem_req_t cmd_req_i,
    input  uart_ldr_pkg::mem_req_t core_req_i,
    output uart_ldr_pkg::mem_rsp_t cmd_rsp_o,
    output uart_ldr_pkg::mem_rsp_t core_rsp_o,
    output uart_ldr_pkg::mem_req_t ram_req_o,
    input  uart_ldr_pkg::word_t    ram_rdata_i
);

    import uart_ldr_pkg::*;

    logic rr_core;    // Core side wins the next tie
    logic cmd_gnt;
    logic core_gnt;
    logic rd_pend;
    logic rd_core;

    assign cmd_gnt  = cmd_req_i.valid && (!core_req_i.valid || !rr_core);
    assign core_gnt = core_req_i.valid && (!cmd_req_i.valid || rr_core);

    always_comb begin
        ram_req_o       = core_gnt ? core_req_i : cmd_req_i;
        ram_req_o.valid = cmd_gnt || core_gnt;

        cmd_rsp_o.gnt    = cmd_gnt;
        cmd_rsp_o.rvalid = rd_pend && !rd_core;
        cmd_rsp_o.rdata  = ram_rdata_i;

        core_rsp_o.gnt    = core_gnt;
        core_rsp_o.rvalid = rd_pend && rd_core;
        core_rsp_o.rdata  = ram_rdata_i;
    end

    // The last master served loses priority, so a tie alternates
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rr_core <= 1'b0;
            rd_pend <= 1'b0;
            rd_core <= 1'b0;
        end else begin
            if (cmd_gnt || core_gnt) rr_core <= cmd_gnt;
            rd_pend <= ram_req_o.valid && !ram_req_o.write;
            rd_core <= core_gnt;
        end
    end

endmodule

// ==== logic/ram_cmd.sv ====
`timescale 1ns/1ps

module ram_cmd (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  uart_ldr_pkg::byte_t    rx_byte_i,
    input  logic                   rx_push_i,
    output logic                   rx_credit_o,
    output uart_ldr_pkg::byte_t    tx_byte_o,
    output logic                   tx_push_o,
    input  logic                   tx_credit_i,
    output uart_ldr_pkg::mem_req_t mem_req_o,
    input  uart_ldr_pkg::mem_rsp_t mem_rsp_i,
    output logic                   cpu_run_o
);

    import uart_ldr_pkg::*;

    typedef enum logic [2:0] {ST_IDLE, ST_ADDR, ST_DATA, ST_MEM, ST_REPLY} cmd_state_t;

    cmd_state_t state;

    // Landing slots for the bytes the receiver holds credits for
    byte_t      in_mem [RX_CREDITS];
    rx_ptr_t    in_wr;
    rx_ptr_t    in_rd;
    rx_cnt_t    in_cnt;
    byte_t      in_byte;
    logic       take;

    tx_cnt_t    tx_credits;
    logic       op_write;
    addr_t      cmd_addr;
    word_t      cmd_data;
    logic [1:0] byte_idx;
    logic       rd_wait;
    word_t      reply_buf;
    logic [2:0] reply_left;

    assign in_byte     = in_mem[in_rd];
    assign take        = in_cnt != '0 && (state == ST_IDLE || state == ST_ADDR || state == ST_DATA);
    assign rx_credit_o = take;

    assign tx_push_o = state == ST_REPLY && tx_credits != '0;
    assign tx_byte_o = reply_buf[7:0];

    always_comb begin
        mem_req_o.valid = state == ST_MEM && !rd_wait;
        mem_req_o.write = op_write;
        mem_req_o.addr  = cmd_addr;
        mem_req_o.wdata = cmd_data;
        mem_req_o.be    = '1;   // Host access is always a full word
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Input slots and transmit credits
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            in_wr      <= '0;
            in_rd      <= '0;
            in_cnt     <= '0;
            tx_credits <= tx_cnt_t'(TX_CREDITS);
        end else begin
            if (rx_push_i) in_wr <= in_wr + rx_ptr_t'(1);
            if (take) in_rd <= in_rd + rx_ptr_t'(1);
            in_cnt     <= in_cnt + rx_cnt_t'(rx_push_i) - rx_cnt_t'(take);
            tx_credits <= tx_credits + tx_cnt_t'(tx_credit_i) - tx_cnt_t'(tx_push_o);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Command FSM
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state      <= ST_IDLE;
            byte_idx   <= '0;
            rd_wait    <= 1'b0;
            reply_left <= '0;
            cpu_run_o  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: if (take) begin
                    reply_left <= 3'd1;
                    case (in_byte)
                        CMD_WRITE, CMD_READ: state <= ST_ADDR;
                        CMD_GO: begin
                            cpu_run_o <= 1'b1;
                            state     <= ST_REPLY;
                        end
                        CMD_HALT: begin
                            cpu_run_o <= 1'b0;
                            state     <= ST_REPLY;
                        end
                        default: state <= ST_REPLY;   // Unknown opcode gets a NAK
                    endcase
                end
                ST_ADDR: if (take) begin
                    byte_idx <= '0;
                    state    <= op_write ? ST_DATA : ST_MEM;
                end
                ST_DATA: if (take) begin
                    byte_idx <= byte_idx + 2'd1;
                    if (byte_idx == 2'd3) state <= ST_MEM;
                end
                ST_MEM: begin
                    if (rd_wait) begin
                        if (mem_rsp_i.rvalid) begin
                            rd_wait    <= 1'b0;
                            reply_left <= 3'd4;
                            state      <= ST_REPLY;
                        end
                    end else if (mem_rsp_i.gnt) begin
                        if (op_write) begin
                            reply_left <= 3'd1;
                            state      <= ST_REPLY;
                        end else begin
                            rd_wait <= 1'b1;
                        end
                    end
                end
                ST_REPLY: if (tx_push_o) begin
                    reply_left <= reply_left - 3'd1;
                    if (reply_left == 3'd1) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rx_push_i) in_mem[in_wr] <= rx_byte_i;
        if (take) begin
            case (state)
                ST_IDLE: begin
                    op_write  <= in_byte == CMD_WRITE;
                    reply_buf <= {24'd0, (in_byte == CMD_GO || in_byte == CMD_HALT) ?
                                         RSP_ACK : RSP_NAK};
                end
                ST_ADDR: cmd_addr <= in_byte;
                ST_DATA: cmd_data <= {in_byte, cmd_data[31:8]};   // Data arrives LSB first
                default: ;
            endcase
        end
        if (state == ST_MEM && mem_rsp_i.gnt && op_write) reply_buf <= {24'd0, RSP_ACK};
        if (rd_wait && mem_rsp_i.rvalid) reply_buf <= mem_rsp_i.rdata;
        if (tx_push_o) reply_buf <= {8'd0, reply_buf[31:8]};
    end

endmodule

// ==== logic/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
    input  logic                clk_i,
    input  logic                rst_i,
    input  uart_ldr_pkg::byte_t tx_byte_i,
    input  logic                tx_push_i,
    output logic                uart_tx_o,
    output logic                tx_credit_o
);

    import uart_ldr_pkg::*;

    byte_t      fifo_mem [TX_CREDITS];
    tx_ptr_t    wr_ptr;
    tx_ptr_t    rd_ptr;
    tx_cnt_t    fifo_cnt;

    logic       busy;
    baud_t      baud_cnt;
    logic [3:0] bit_cnt;     // 0 is the start bit, 9 the stop bit
    logic [8:0] shift;
    logic       baud_end;
    logic       frame_end;
    logic       pop;

    assign baud_end  = baud_cnt == baud_t'(BAUD_DIV - 1);
    assign frame_end = busy && baud_end && bit_cnt == 4'd9;

    // A new frame may follow the stop bit with no idle gap
    assign pop         = fifo_cnt != '0 && (!busy || frame_end);
    assign tx_credit_o = pop;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Byte FIFO
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            if (tx_push_i) wr_ptr <= wr_ptr + tx_ptr_t'(1);
            if (pop) rd_ptr <= rd_ptr + tx_ptr_t'(1);
            fifo_cnt <= fifo_cnt + tx_cnt_t'(tx_push_i) - tx_cnt_t'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (tx_push_i) fifo_mem[wr_ptr] <= tx_byte_i;
        if (pop) begin
            shift <= {1'b1, fifo_mem[rd_ptr]};   // Stop bit sits above the data
        end else if (busy && baud_end) begin
            shift <= {1'b1, shift[8:1]};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Serializer
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy      <= 1'b0;
            uart_tx_o <= 1'b1;
            baud_cnt  <= '0;
            bit_cnt   <= '0;
        end else if (pop) begin
            busy      <= 1'b1;
            uart_tx_o <= 1'b0;
            baud_cnt  <= '0;
            bit_cnt   <= '0;
        end else if (busy) begin
            baud_cnt <= baud_end ? '0 : baud_cnt + baud_t'(1);
            if (baud_end) begin
                if (bit_cnt == 4'd9) begin
                    busy <= 1'b0;   // Line stays high after the stop bit
                end else begin
                    uart_tx_o <= shift[0];
                    bit_cnt   <= bit_cnt + 4'd1;
                end
            end
        end
    end

endmodule

// ==== logic/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                uart_rx_i,
    input  logic                rx_credit_i,
    output uart_ldr_pkg::byte_t rx_byte_o,
    output logic                rx_push_o
);

    import uart_ldr_pkg::*;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t  state;
    logic [1:0] line_sync;
    baud_t      baud_cnt;
    logic [2:0] bit_idx;
    byte_t      shift;
    logic       baud_end;
    logic       frame_ok;
    logic       buf_wr;

    byte_t      buf_mem [RX_CREDITS];
    rx_ptr_t    wr_ptr;
    rx_ptr_t    rd_ptr;
    rx_cnt_t    buf_cnt;
    rx_cnt_t    credits;

    assign baud_end  = baud_cnt == baud_t'(BAUD_DIV - 1);
    assign frame_ok  = state == RX_STOP && baud_end && line_sync[1];
    assign buf_wr    = frame_ok && buf_cnt != rx_cnt_t'(RX_CREDITS);   // Full buffer drops the byte
    assign rx_push_o = buf_cnt != '0 && credits != '0;
    assign rx_byte_o = buf_mem[rd_ptr];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame decoder
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            line_sync <= 2'b11;
            state     <= RX_IDLE;
            baud_cnt  <= '0;
            bit_idx   <= '0;
        end else begin
            line_sync <= {line_sync[0], uart_rx_i};
            baud_cnt  <= baud_cnt + baud_t'(1);
            case (state)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    if (!line_sync[1]) state <= RX_START;
                end
                RX_START: if (baud_cnt == baud_t'(BAUD_DIV / 2 - 1)) begin
                    baud_cnt <= '0;
                    bit_idx  <= '0;
                    state    <= line_sync[1] ? RX_IDLE : RX_DATA;   // High at mid-bit is a glitch
                end
                RX_DATA: if (baud_end) begin
                    baud_cnt <= '0;
                    bit_idx  <= bit_idx + 3'd1;
                    if (bit_idx == 3'd7) state <= RX_STOP;
                end
                RX_STOP: if (baud_end) state <= RX_IDLE;
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == RX_DATA && baud_end) shift <= {line_sync[1], shift[7:1]};   // LSB first
        if (buf_wr) buf_mem[wr_ptr] <= shift;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Byte buffer and credit count
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            buf_cnt <= '0;
            credits <= rx_cnt_t'(RX_CREDITS);
        end else begin
            if (buf_wr) wr_ptr <= wr_ptr + rx_ptr_t'(1);
            if (rx_push_o) rd_ptr <= rd_ptr + rx_ptr_t'(1);
            buf_cnt <= buf_cnt + rx_cnt_t'(buf_wr) - rx_cnt_t'(rx_push_o);
            credits <= credits + rx_cnt_t'(rx_credit_i) - rx_cnt_t'(rx_push_o);
        end
    end

endmodule

// ==== logic/uart_ldr_pkg.sv ====
package uart_ldr_pkg;

    // Data widths
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0]  addr_t;
    typedef logic [3:0]  be_t;

    localparam int MEM_WORDS  = 256;
    localparam int BAUD_DIV   = 8;     // Clock cycles per serial bit
    localparam int RX_CREDITS = 2;
    localparam int TX_CREDITS = 4;

    // Counter and pointer widths derived from the depths above
    typedef logic [$clog2(BAUD_DIV)-1:0]     baud_t;
    typedef logic [$clog2(RX_CREDITS+1)-1:0] rx_cnt_t;
    typedef logic [$clog2(TX_CREDITS+1)-1:0] tx_cnt_t;
    typedef logic [$clog2(RX_CREDITS)-1:0]   rx_ptr_t;
    typedef logic [$clog2(TX_CREDITS)-1:0]   tx_ptr_t;

    // Host command opcodes
    localparam byte_t CMD_WRITE = 8'h57;
    localparam byte_t CMD_READ  = 8'h52;
    localparam byte_t CMD_GO    = 8'h47;
    localparam byte_t CMD_HALT  = 8'h48;

    localparam byte_t RSP_ACK = 8'h06;
    localparam byte_t RSP_NAK = 8'h15;

    // Memory bus between a master, the arbiter and the RAM
    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t addr;
        word_t wdata;
        be_t   be;
    } mem_req_t;

    typedef struct packed {
        logic  gnt;
        logic  rvalid;   // One cycle after a read grant
        word_t rdata;
    } mem_rsp_t;

endpackage
